// ==== include/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data path width
`define EX_DATA_W 16
// eight architectural registers
`define EX_REG_W 3
// 4 major opcode bits plus 2 condition bits
`define EX_OPC_W 6

`endif

// ==== hw/exec_pkg.sv ====
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

	// {major[3:0], cond[1:0]} as taken from the instruction word
	typedef enum logic [`EX_OPC_W-1:0] {
		op_add = 6'b000000,
		op_adz = 6'b000001, // runs only if zero set
		op_adc = 6'b000010, // runs only if carry set
		op_adi = 6'b000100,
		op_ndu = 6'b001000,
		op_ndz = 6'b001001,
		op_ndc = 6'b001010,
		op_lw  = 6'b010000  // alu used as address adder
	} ex_op_e;

	typedef enum logic [1:0] {
		fwd_rf = 2'd0, // register file read
		fwd_ex = 2'd1, // own ex/mem register
		fwd_wb = 2'd2  // writeback bus
	} fwd_sel_e;

	typedef struct packed {
		logic zero;
		logic carry;
	} flags_t;

	// instruction entering execute
	typedef struct packed {
		logic                 valid;
		ex_op_e               op;
		logic [`EX_REG_W-1:0]  ra;
		logic [`EX_REG_W-1:0]  rb;
		logic [`EX_REG_W-1:0]  rc;
		logic [`EX_DATA_W-1:0] rf_a;  // rf value of ra
		logic [`EX_DATA_W-1:0] rf_b;  // rf value of rb
		logic [`EX_DATA_W-1:0] imm;   // already sign extended
	} issue_t;

	// instruction retiring from writeback
	typedef struct packed {
		logic                 valid;
		logic [`EX_REG_W-1:0]  dest;
		logic [`EX_DATA_W-1:0] value;
		logic                 reg_write;
		logic                 flag_write;
		flags_t               flags;
	} wb_t;

	// ex/mem pipeline register
	typedef struct packed {
		logic                 valid;
		ex_op_e               op;
		logic [`EX_REG_W-1:0]  dest;
		logic [`EX_DATA_W-1:0] value;
		logic                 reg_write;
		logic                 flag_write;
		flags_t               flags;
	} ex_result_t;

endpackage

`default_nettype wire

// ==== hw/operand_forward.sv ====
`default_nettype none

`include "exec_cfg.svh"

module operand_forward (
	input  exec_pkg::issue_t      issue,
	input  exec_pkg::ex_result_t  ex_fwd,
	input  exec_pkg::wb_t         wb,
	input  exec_pkg::flags_t      ccr,
	output logic [`EX_DATA_W-1:0] opnd_a,
	output logic [`EX_DATA_W-1:0] opnd_b,
	output exec_pkg::flags_t      cond_flags
);

	import exec_pkg::*;

	logic [`EX_REG_W-1:0]  reg_a;     // register feeding operand a
	logic [`EX_DATA_W-1:0] rf_val_a;  // its register file value
	logic                  use_imm_b; // adi and lw take imm as b
	fwd_sel_e              sel_a;
	fwd_sel_e              sel_b;

	// ex result wins over wb and loads still in ex/mem are never forwarded
	function automatic fwd_sel_e pick_src(
		input logic [`EX_REG_W-1:0] r,
		input ex_result_t           ex_r,
		input wb_t                  wb_r
	);
		fwd_sel_e sel;
		sel = fwd_rf;
		if (ex_r.valid && ex_r.reg_write && ex_r.op != op_lw && ex_r.dest == r) begin
			sel = fwd_ex;
		end else if (wb_r.valid && wb_r.reg_write && wb_r.dest == r) begin
			sel = fwd_wb;
		end
		return sel;
	endfunction

	// lw reads its base from rb and every other op reads ra first
	always_comb begin
		if (issue.op == op_lw) begin
			reg_a    = issue.rb;
			rf_val_a = issue.rf_b;
		end else begin
			reg_a    = issue.ra;
			rf_val_a = issue.rf_a;
		end
		use_imm_b = (issue.op == op_adi) || (issue.op == op_lw);
	end

	always_comb begin
		sel_a = pick_src(reg_a, ex_fwd, wb);
		if (use_imm_b) begin
			sel_b = fwd_rf; // immediate path has nothing to forward
		end else begin
			sel_b = pick_src(issue.rb, ex_fwd, wb);
		end
	end

	always_comb begin
		case (sel_a)
			fwd_ex:  opnd_a = ex_fwd.value;
			fwd_wb:  opnd_a = wb.value;
			default: opnd_a = rf_val_a;
		endcase
	end

	always_comb begin
		if (use_imm_b) begin
			opnd_b = issue.imm;
		end else begin
			case (sel_b)
				fwd_ex:  opnd_b = ex_fwd.value;
				fwd_wb:  opnd_b = wb.value;
				default: opnd_b = issue.rf_b;
			endcase
		end
	end

	// newest flag writer first with ccr as the fallback
	always_comb begin
		if (ex_fwd.valid && ex_fwd.flag_write) begin
			cond_flags = ex_fwd.flags;
		end else if (wb.valid && wb.flag_write) begin
			cond_flags = wb.flags;
		end else begin
			cond_flags = ccr;
		end
	end

endmodule

`default_nettype wire

// ==== hw/alu_flags.sv ====
`default_nettype none

`include "exec_cfg.svh"

module alu_flags (
	input  exec_pkg::ex_op_e      op,
	input  logic [`EX_DATA_W-1:0] opnd_a,
	input  logic [`EX_DATA_W-1:0] opnd_b,
	input  exec_pkg::flags_t      cond_flags,
	output logic [`EX_DATA_W-1:0] value,
	output exec_pkg::flags_t      new_flags,
	output logic                  executed
);

	import exec_pkg::*;

	logic [`EX_DATA_W:0]   sum;      // one extra bit for carry out
	logic [`EX_DATA_W-1:0] nand_out;
	logic                  is_nand;

	assign sum      = {1'b0, opnd_a} + {1'b0, opnd_b};
	assign nand_out = ~(opnd_a & opnd_b);

	always_comb begin
		case (op)
			op_ndu, op_ndc, op_ndz: is_nand = 1'b1;
			default:                is_nand = 1'b0;
		endcase
	end

	assign value = is_nand ? nand_out : sum[`EX_DATA_W-1:0];

	// nand never produces a carry
	always_comb begin
		new_flags.zero  = (value == '0);
		new_flags.carry = is_nand ? 1'b0 : sum[`EX_DATA_W];
	end

	// conditional ops take effect only when their flag is set
	always_comb begin
		case (op)
			op_adc, op_ndc:                executed = cond_flags.carry;
			op_adz, op_ndz:                executed = cond_flags.zero;
			op_add, op_adi, op_ndu, op_lw: executed = 1'b1;
			default:                       executed = 1'b0; // not an execute op
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/ex_stage.sv ====
`default_nettype none

`include "exec_cfg.svh"

module ex_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  exec_pkg::issue_t     issue,
	input  exec_pkg::wb_t        wb,
	output exec_pkg::ex_result_t result,
	output exec_pkg::flags_t     ccr
);

	import exec_pkg::*;

	logic [`EX_DATA_W-1:0] opnd_a;
	logic [`EX_DATA_W-1:0] opnd_b;
	logic [`EX_DATA_W-1:0] alu_value;
	logic [`EX_REG_W-1:0]  dest;
	flags_t                cond_flags;
	flags_t                new_flags;
	logic                  executed;
	logic                  is_lw;

	operand_forward u_operand_forward (
		.issue      (issue),
		.ex_fwd     (result), // own ex/mem register fed back
		.wb         (wb),
		.ccr        (ccr),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b),
		.cond_flags (cond_flags)
	);

	alu_flags u_alu_flags (
		.op         (issue.op),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b),
		.cond_flags (cond_flags),
		.value      (alu_value),
		.new_flags  (new_flags),
		.executed   (executed)
	);

	assign is_lw = (issue.op == op_lw);

	// destination field depends on the instruction format
	always_comb begin
		case (issue.op)
			op_adi:  dest = issue.rb;
			op_lw:   dest = issue.ra;
			default: dest = issue.rc; // r-type
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			result.valid      <= 1'b0;
			result.reg_write  <= 1'b0;
			result.flag_write <= 1'b0;
		end else begin
			result.valid      <= issue.valid;
			result.reg_write  <= issue.valid && executed;
			result.flag_write <= issue.valid && executed && !is_lw; // lw keeps flags
		end
		result.op    <= issue.op;
		result.dest  <= dest;
		result.value <= alu_value;
		result.flags <= new_flags;
	end

	// condition register written only from writeback
	always_ff @(posedge clk) begin
		if (!reset) begin
			ccr <= '0;
		end else if (wb.valid && wb.flag_write) begin
			ccr <= wb.flags;
		end
	end

	// unconditional alu ops always write their register and both flags
	assert property (@(posedge clk) disable iff (!reset)
		(result.valid && (result.op == op_add || result.op == op_adi || result.op == op_ndu))
			|-> (result.reg_write && result.flag_write))
		else $error("unconditional op did not write its register and flags");

	assert property (@(posedge clk) disable iff (!reset)
		(result.valid && result.op == op_lw) |-> (result.reg_write && !result.flag_write))
		else $error("load result must write its register and never the flags");

endmodule

`default_nettype wire

// ==== tests/ex_checker.sv ====
`default_nettype none

module ex_checker (
	input  logic                 clk,
	input  logic                 reset,
	input  exec_pkg::ex_result_t result,
	input  exec_pkg::flags_t     ccr,
	input  logic                 check_en,  // a row was driven this cycle
	input  int                   row_id,
	input  exec_pkg::ex_result_t want,
	input  exec_pkg::flags_t     want_ccr,
	output int                   rows_done,
	output int                   errors
);

	import exec_pkg::*;

	logic       pend;        // row now held in ex/mem
	logic       after_reset; // first cycle out of reset
	int         pend_row;
	ex_result_t pend_want;
	flags_t     pend_ccr;
	int         row_bad;
	string      where;

	// follows the one cycle latency of the stage
	always_ff @(posedge clk) begin
		if (!reset) begin
			pend <= 1'b0;
		end else begin
			pend <= check_en;
		end
		after_reset <= !reset;
		pend_row    <= row_id;
		pend_want   <= want;
		pend_ccr    <= want_ccr;
	end

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp_v);
		if (got !== exp_v) begin
			$display("mismatch %s %s: got %h expected %h", name, where, got, exp_v);
			row_bad++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			rows_done = 0;
			errors    = 0;
		end else if (after_reset) begin
			where   = "after reset";
			row_bad = 0;
			check_field("result.valid", 32'(result.valid), 32'h0);
			check_field("result.reg_write", 32'(result.reg_write), 32'h0);
			check_field("result.flag_write", 32'(result.flag_write), 32'h0);
			check_field("ccr", 32'(ccr), 32'h0);
			if (row_bad == 0) begin
				$display("reset state: ok");
			end else begin
				$display("reset state: %0d fields wrong", row_bad);
			end
			errors = errors + row_bad;
		end else if (pend) begin
			where   = $sformatf("row %0d", pend_row);
			row_bad = 0;
			check_field("result.valid", 32'(result.valid), 32'(pend_want.valid));
			check_field("result.reg_write", 32'(result.reg_write), 32'(pend_want.reg_write));
			check_field("result.flag_write", 32'(result.flag_write), 32'(pend_want.flag_write));
			if (pend_want.valid) begin
				check_field("result.op", 32'(result.op), 32'(pend_want.op));
			end
			if (pend_want.reg_write) begin // dest and value only matter when written
				check_field("result.dest", 32'(result.dest), 32'(pend_want.dest));
				check_field("result.value", 32'(result.value), 32'(pend_want.value));
			end
			if (pend_want.flag_write) begin
				check_field("result.flags", 32'(result.flags), 32'(pend_want.flags));
			end
			check_field("ccr", 32'(ccr), 32'(pend_ccr));
			if (row_bad == 0) begin
				$display("row %0d: ok", pend_row);
			end else begin
				$display("row %0d: %0d fields wrong", pend_row, row_bad);
			end
			rows_done = rows_done + 1;
			errors    = errors + row_bad;
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_ex_stage.sv ====
`default_nettype none

`include "exec_cfg.svh"

module tb_ex_stage;

	import exec_pkg::*;

	typedef struct packed {
		issue_t     issue;
		wb_t        wb;
		ex_result_t want;
		flags_t     want_ccr; // ccr after the row's edge
	} row_t;

	localparam issue_t     no_issue  = '0;
	localparam wb_t        no_wb     = '0;
	localparam ex_result_t no_result = '0;

	logic       clk;
	logic       reset;
	issue_t     issue;
	wb_t        wb;
	ex_result_t result;
	flags_t     ccr;
	logic       check_en;
	int         row_id;
	ex_result_t want;
	flags_t     want_ccr;
	int         rows_done;
	int         errors;
	int         cycle_count;
	int         cycle_limit;
	row_t       table_q[$];

	ex_stage u_ex_stage (
		.clk    (clk),
		.reset  (reset),
		.issue  (issue),
		.wb     (wb),
		.result (result),
		.ccr    (ccr)
	);

	ex_checker u_ex_checker (
		.clk       (clk),
		.reset     (reset),
		.result    (result),
		.ccr       (ccr),
		.check_en  (check_en),
		.row_id    (row_id),
		.want      (want),
		.want_ccr  (want_ccr),
		.rows_done (rows_done),
		.errors    (errors)
	);

	function automatic issue_t issue_of(ex_op_e op, int ra, int rb, int rc,
		logic [`EX_DATA_W-1:0] a, logic [`EX_DATA_W-1:0] b, logic [`EX_DATA_W-1:0] imm);
		issue_t r;
		r       = '0;
		r.valid = 1'b1;
		r.op    = op;
		r.ra    = ra[`EX_REG_W-1:0];
		r.rb    = rb[`EX_REG_W-1:0];
		r.rc    = rc[`EX_REG_W-1:0];
		r.rf_a  = a;
		r.rf_b  = b;
		r.imm   = imm;
		return r;
	endfunction

	// wr is {reg_write, flag_write}
	function automatic wb_t wb_of(int dest, logic [`EX_DATA_W-1:0] value,
		logic [1:0] wr, flags_t flags);
		wb_t w;
		w.valid      = 1'b1;
		w.dest       = dest[`EX_REG_W-1:0];
		w.value      = value;
		w.reg_write  = wr[1];
		w.flag_write = wr[0];
		w.flags      = flags;
		return w;
	endfunction

	function automatic ex_result_t result_of(ex_op_e op, int dest,
		logic [`EX_DATA_W-1:0] value, logic [1:0] wr, flags_t flags);
		ex_result_t e;
		e.valid      = 1'b1;
		e.op         = op;
		e.dest       = dest[`EX_REG_W-1:0];
		e.value      = value;
		e.reg_write  = wr[1];
		e.flag_write = wr[0];
		e.flags      = flags;
		return e;
	endfunction

	task automatic add_row(issue_t i, wb_t w, ex_result_t e, flags_t c);
		row_t r;
		r.issue    = i;
		r.wb       = w;
		r.want     = e;
		r.want_ccr = c;
		table_q.push_back(r);
	endtask

	// flags are {zero, carry}
	task automatic load_table();
		add_row(no_issue, no_wb, no_result, 2'b00); // idle after reset
		add_row(issue_of(op_add, 1, 2, 3, 16'h1234, 16'h0101, 16'h0), no_wb,
			result_of(op_add, 3, 16'h1335, 2'b11, 2'b00), 2'b00);
		add_row(issue_of(op_add, 4, 5, 6, 16'hffff, 16'h0001, 16'h0), no_wb,
			result_of(op_add, 6, 16'h0000, 2'b11, 2'b11), 2'b00); // wraps with carry
		add_row(issue_of(op_ndu, 1, 2, 7, 16'hf0f0, 16'hff00, 16'h0), no_wb,
			result_of(op_ndu, 7, 16'h0fff, 2'b11, 2'b00), 2'b00);
		add_row(issue_of(op_ndu, 1, 2, 5, 16'hffff, 16'hffff, 16'h0), no_wb,
			result_of(op_ndu, 5, 16'h0000, 2'b11, 2'b10), 2'b00);
		add_row(issue_of(op_add, 5, 1, 2, 16'h1111, 16'h0003, 16'h0), no_wb,
			result_of(op_add, 2, 16'h0003, 2'b11, 2'b00), 2'b00); // r5 from ex
		add_row(issue_of(op_adi, 2, 4, 0, 16'haaaa, 16'h0000, 16'h0010), no_wb,
			result_of(op_adi, 4, 16'h0013, 2'b11, 2'b00), 2'b00);
		add_row(issue_of(op_add, 3, 4, 1, 16'h0100, 16'h5555, 16'h0), no_wb,
			result_of(op_add, 1, 16'h0113, 2'b11, 2'b00), 2'b00); // adi dest forwarded
		add_row(issue_of(op_add, 1, 0, 3, 16'h7777, 16'h0001, 16'h0),
			wb_of(1, 16'h2222, 2'b10, 2'b00),
			result_of(op_add, 3, 16'h0114, 2'b11, 2'b00), 2'b00); // ex beats wb
		add_row(issue_of(op_add, 6, 7, 0, 16'h1000, 16'h0020, 16'h0),
			wb_of(6, 16'h0200, 2'b10, 2'b00),
			result_of(op_add, 0, 16'h0220, 2'b11, 2'b00), 2'b00); // wb only
		add_row(issue_of(op_lw, 6, 3, 0, 16'h0000, 16'h0300, 16'h0004), no_wb,
			result_of(op_lw, 6, 16'h0304, 2'b10, 2'b00), 2'b00);
		add_row(issue_of(op_add, 6, 2, 1, 16'h0040, 16'h0002, 16'h0), no_wb,
			result_of(op_add, 1, 16'h0042, 2'b11, 2'b00), 2'b00); // load not forwarded
		add_row(issue_of(op_adc, 1, 2, 4, 16'h0001, 16'h0001, 16'h0), no_wb,
			result_of(op_adc, 4, 16'h0000, 2'b00, 2'b00), 2'b00);
		add_row(issue_of(op_adc, 1, 2, 4, 16'h8000, 16'h8001, 16'h0),
			wb_of(0, 16'h0000, 2'b01, 2'b01),
			result_of(op_adc, 4, 16'h0001, 2'b11, 2'b01), 2'b01); // carry from wb
		add_row(issue_of(op_ndc, 5, 6, 7, 16'h00ff, 16'h0f0f, 16'h0), no_wb,
			result_of(op_ndc, 7, 16'hfff0, 2'b11, 2'b00), 2'b01);
		add_row(issue_of(op_ndc, 5, 6, 7, 16'h00ff, 16'h0f0f, 16'h0), no_wb,
			result_of(op_ndc, 7, 16'h0000, 2'b00, 2'b00), 2'b01);
		add_row(issue_of(op_adz, 1, 2, 3, 16'h0007, 16'h0009, 16'h0), no_wb,
			result_of(op_adz, 3, 16'h0000, 2'b00, 2'b00), 2'b01); // zero clear in ccr
		add_row(no_issue, wb_of(0, 16'h0000, 2'b01, 2'b10), no_result, 2'b10);
		add_row(issue_of(op_adz, 1, 2, 3, 16'h0007, 16'h0009, 16'h0), no_wb,
			result_of(op_adz, 3, 16'h0010, 2'b11, 2'b00), 2'b10); // zero from ccr
		add_row(issue_of(op_ndz, 3, 3, 2, 16'h0010, 16'h0010, 16'h0), no_wb,
			result_of(op_ndz, 2, 16'h0000, 2'b00, 2'b00), 2'b10);
		add_row(issue_of(op_ndz, 4, 5, 2, 16'hffff, 16'hffff, 16'h0), no_wb,
			result_of(op_ndz, 2, 16'h0000, 2'b11, 2'b10), 2'b10);
		add_row(issue_of(op_adz, 2, 1, 5, 16'h1234, 16'h0004, 16'h0), no_wb,
			result_of(op_adz, 5, 16'h0004, 2'b11, 2'b00), 2'b10);
		add_row(issue_of(op_add, 5, 5, 6, 16'h0001, 16'h0001, 16'h0), no_wb,
			result_of(op_add, 6, 16'h0008, 2'b11, 2'b00), 2'b10); // both from ex
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		do begin
			@(posedge clk);
			cycle_count++;
		end while (cycle_count <= cycle_limit);
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		reset    = 1'b0;
		issue    = issue_of(op_add, 1, 2, 3, 16'h0001, 16'h0001, 16'h0); // blocked by reset
		wb       = wb_of(0, 16'h0000, 2'b01, 2'b11); // ccr must ignore it in reset
		check_en = 1'b0;
		row_id   = 0;
		want     = no_result;
		want_ccr = '0;
		load_table();
		cycle_limit = table_q.size() + 4 + 20;
		repeat (4) @(posedge clk);
		reset <= 1'b1;
		issue <= no_issue;
		wb    <= no_wb;
		foreach (table_q[i]) begin
			@(posedge clk);
			issue    <= table_q[i].issue;
			wb       <= table_q[i].wb;
			want     <= table_q[i].want;
			want_ccr <= table_q[i].want_ccr;
			check_en <= 1'b1;
			row_id   <= i;
		end
		@(posedge clk);
		issue    <= no_issue;
		wb       <= no_wb;
		check_en <= 1'b0;
		@(posedge clk);
		@(negedge clk); // last row checked by now
		$display("%0d of %0d rows checked, %0d errors", rows_done, table_q.size(), errors);
		if (errors == 0 && rows_done == table_q.size()) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== ex_stage.f ====
+incdir+include
hw/exec_pkg.sv
hw/operand_forward.sv
hw/alu_flags.sv
hw/ex_stage.sv
tests/ex_checker.sv
tests/tb_ex_stage.sv

// ==== Makefile ====
TOP = tb_ex_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f ex_stage.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
